// File: busCycle_macros.svh
// Address-map codes and wait counts, included by the sequencer, decoder and testbench
`ifndef BUSCYCLE_MACROS_SVH
`define BUSCYCLE_MACROS_SVH

////////////////////////////////////////
// Upper address codes, bits 31..20
////////////////////////////////////////

// Boot ROM at 0x00F00000
`define ROM_BASE 12'h00F
// Chip RAM, 0x00000000 to 0x001FFFFF, low bit ignored
`define CHIP_BASE 12'h000
// Custom chip registers at 0x00D00000
`define REG_BASE 12'h00D
// Fast RAM, bits 31..27, 0x08000000 to 0x0FFFFFFF
`define FAST_TOP_BITS 5'b00001

////////////////////////////////////////
// Wait cycles per region
////////////////////////////////////////

// Width of the wait counter
`define WAIT_BITS 3
`define ROM_WAIT 3'd3
`define CHIP_WAIT 3'd5
`define REG_WAIT 3'd4
`define FAST_WAIT 3'd1
// Unmapped space ends with a bus error right away
`define NONE_WAIT 3'd0

`endif

// File: addrMapPkg.sv
// Address-map types shared by the decoder, the sequencer and the cycle interface
package addrMapPkg;

    ////////////////////////////////////////
    // Memory regions
    ////////////////////////////////////////

    // One region per decoded processor cycle
    typedef enum logic [2:0] {
        REGION_ROM  = 3'd0,
        REGION_CHIP = 3'd1,
        REGION_REG  = 3'd2,
        REGION_FAST = 3'd3,
        REGION_NONE = 3'd4
    } memRegion_t;

    ////////////////////////////////////////
    // Region attributes
    ////////////////////////////////////////

    // Driven onto nTCI and nTBI with the acknowledge
    // Chip RAM and registers can change behind the CPU, so no caching there
    // Only fast RAM supports line bursts
    typedef struct packed {
        logic cacheInhibit;
        logic burstInhibit;
    } regionAttr_t;

endpackage

// File: busCyclePkg.sv
// Bus-cycle types shared by the sequencer, the acknowledge driver and the cycle interface
package busCyclePkg;

    ////////////////////////////////////////
    // Sequencer states
    ////////////////////////////////////////

    // IDLE waits for nTS, WAIT counts down, END holds the strobe
    typedef enum logic [1:0] {
        SEQ_IDLE = 2'd0,
        SEQ_WAIT = 2'd1,
        SEQ_END  = 2'd2
    } seqState_t;

    ////////////////////////////////////////
    // Cycle termination
    ////////////////////////////////////////

    // Normal end with nTA, or bus error with nTEA
    typedef enum logic {
        TERM_ACK   = 1'b0,
        TERM_ERROR = 1'b1
    } termKind_t;

endpackage

// File: cycleIf.sv
// Cycle interface between the sequencer and the acknowledge driver, one instance per top
`timescale 1ns/1ps

interface cycleIf;
    import addrMapPkg::*;
    import busCyclePkg::*;

    // Decoded region, held from the start latch to the next start
    memRegion_t region;
    // Cache and burst inhibit of that region
    regionAttr_t attr;
    // Ack or error, valid with endStrobe
    termKind_t term;
    // Single-cycle termination strobe
    logic endStrobe;
    // High from the latched start until the strobe
    logic active;

    // Sequencer side owns every signal
    modport seq (
        output region,
        output attr,
        output term,
        output endStrobe,
        output active
    );

    // Driver side only needs the termination and its attributes
    // No back-pressure, every strobe is taken as it comes
    modport drv (
        input attr,
        input term,
        input endStrobe
    );

endinterface

// File: addrDecode.sv
// Combinational decoder from address bits 31..20 and OVL to memory region and attributes
`timescale 1ns/1ps
`include "busCycle_macros.svh"

module addrDecode (
    input  logic [31:20]            addr,
    input  logic                    OVL,
    output addrMapPkg::memRegion_t  region,
    output addrMapPkg::regionAttr_t attr
);
    import addrMapPkg::*;

    ////////////////////////////////////////
    // Region hits
    ////////////////////////////////////////

    logic chipSpace;
    logic romHit;
    logic chipHit;
    logic regHit;
    logic fastHit;
    logic noneHit;

    // Chip RAM spans two 1 MB codes, low bit ignored
    assign chipSpace = ((addr & 12'hFFE) == `CHIP_BASE);

    // Overlay after reset maps ROM at address zero
    assign romHit = (addr == `ROM_BASE) || (OVL && chipSpace);
    assign chipHit = !OVL && chipSpace;
    assign regHit = (addr == `REG_BASE);
    // Fast RAM only looks at the top five bits
    assign fastHit = (addr[31:27] == `FAST_TOP_BITS);
    // Anything else ends in a bus error
    assign noneHit = !(romHit || chipHit || regHit || fastHit);

    ////////////////////////////////////////
    // Region and attributes
    ////////////////////////////////////////

    always_comb begin
        if (romHit) begin
            region = REGION_ROM;
        end else if (chipHit) begin
            region = REGION_CHIP;
        end else if (regHit) begin
            region = REGION_REG;
        end else if (fastHit) begin
            region = REGION_FAST;
        end else begin
            region = REGION_NONE;
        end
    end

    // Agnus and the custom chips can write here, so the CPU must not cache it
    assign attr.cacheInhibit = (region == REGION_CHIP) || (region == REGION_REG);
    // Bursts only into fast RAM
    assign attr.burstInhibit = (region != REGION_FAST);

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // The map has no overlaps, so one hit per address
    always_comb begin
        assert ($onehot({romHit, chipHit, regHit, fastHit, noneHit}))
        else $error("addrDecode: %0d regions match addr %h", 
            $countones({romHit, chipHit, regHit, fastHit, noneHit}), addr);
    end

endmodule

// File: cycleSequencer.sv
// Per-cycle sequencer: latches nTS and region, counts the wait states, strobes termination
`timescale 1ns/1ps
`include "busCycle_macros.svh"

module cycleSequencer (
    input  logic                    CLK40,
    input  logic                    TS_RESET,
    input  logic                    nTS,
    input  addrMapPkg::memRegion_t  region,
    input  addrMapPkg::regionAttr_t attr,
    cycleIf.seq                     bus,
    output logic                    nROMEN
);
    import addrMapPkg::*;
    import busCyclePkg::*;

    seqState_t             seqState;
    logic [`WAIT_BITS-1:0] waitCnt;
    logic                  startTs;

    // Wait cycles of each region
    function automatic logic [`WAIT_BITS-1:0] waitOf(input memRegion_t r);
        case (r)
            REGION_ROM:  waitOf = `ROM_WAIT;
            REGION_CHIP: waitOf = `CHIP_WAIT;
            REGION_REG:  waitOf = `REG_WAIT;
            REGION_FAST: waitOf = `FAST_WAIT;
            default:     waitOf = `NONE_WAIT;
        endcase
    endfunction

    ////////////////////////////////////////
    // Start latch
    ////////////////////////////////////////

    // nTS is a one-clock pulse, taken only between cycles
    // A start in SEQ_END gives back-to-back cycles
    assign startTs = !nTS && !bus.active;

    ////////////////////////////////////////
    // Cycle FSM
    ////////////////////////////////////////

    always_ff @(posedge CLK40 or posedge TS_RESET) begin
        if (TS_RESET) begin
            seqState      <= SEQ_IDLE;
            waitCnt       <= '0;
            bus.active    <= 1'b0;
            bus.endStrobe <= 1'b0;
            nROMEN        <= 1'b1;
        end else begin
            case (seqState)
                SEQ_IDLE, SEQ_END: begin
                    // Strobe lasts one clock
                    bus.endStrobe <= 1'b0;
                    if (startTs) begin
                        seqState   <= SEQ_WAIT;
                        waitCnt    <= waitOf(region);
                        bus.active <= 1'b1;
                        // Boot ROM enabled for the whole ROM cycle
                        nROMEN     <= (region != REGION_ROM);
                    end else begin
                        seqState <= SEQ_IDLE;
                    end
                end
                SEQ_WAIT: begin
                    if (waitCnt == '0) begin
                        // Wait states done, end the cycle
                        seqState      <= SEQ_END;
                        bus.endStrobe <= 1'b1;
                        bus.active    <= 1'b0;
                        nROMEN        <= 1'b1;
                    end else begin
                        waitCnt <= waitCnt - 1'b1;
                    end
                end
                default: begin
                    seqState <= SEQ_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Cycle payload
    ////////////////////////////////////////

    // Held until the next start, only read while the cycle runs
    always_ff @(posedge CLK40) begin
        if (startTs) begin
            bus.region <= region;
            bus.attr   <= attr;
            // Unmapped space ends with a transfer error
            bus.term   <= (region == REGION_NONE) ? TERM_ERROR : TERM_ACK;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // The driver turns each strobe into one nTA or nTEA clock
    strobeOneCycle: assert property (@(posedge CLK40) disable iff (TS_RESET)
        bus.endStrobe |=> !bus.endStrobe)
    else $error("cycleSequencer: endStrobe longer than one cycle");

    // Counter stays within the wait count of the latched region
    waitInRange: assert property (@(posedge CLK40) disable iff (TS_RESET)
        (seqState == SEQ_WAIT) |-> (waitCnt <= waitOf(bus.region)))
    else $error("cycleSequencer: wait counter %0d above loaded value", waitCnt);

    // CPU must wait for termination before the next nTS
    noTsWhileActive: assert property (@(posedge CLK40) disable iff (TS_RESET)
        bus.active |-> nTS)
    else $error("cycleSequencer: nTS while a cycle is active");

endmodule

// File: ackDriver.sv
// Termination driver: nTA, nTEA, nTCI and nTBI from the end strobe, negated before release
`timescale 1ns/1ps

module ackDriver (
    input  logic CLK40,
    input  logic TS_RESET,
    cycleIf.drv  bus,
    output logic nTA,
    output logic nTEA,
    output logic nTCI,
    output logic nTBI,
    output logic busOe
);
    import busCyclePkg::*;

    logic negateCycle;

    ////////////////////////////////////////
    // Termination lines
    ////////////////////////////////////////

    // Straight from the strobe, no extra clock of latency
    assign nTA = !(bus.endStrobe && (bus.term == TERM_ACK));
    assign nTEA = !(bus.endStrobe && (bus.term == TERM_ERROR));
    // Inhibits only qualify the termination clock
    assign nTCI = !(bus.endStrobe && bus.attr.cacheInhibit);
    assign nTBI = !(bus.endStrobe && bus.attr.burstInhibit);

    ////////////////////////////////////////
    // Negate then release
    ////////////////////////////////////////

    // Lines are shared, so drive them high one clock after termination
    // Otherwise the pull-up is too slow and the next cycle could end early
    always_ff @(posedge CLK40 or posedge TS_RESET) begin
        if (TS_RESET) begin
            negateCycle <= 1'b0;
        end else begin
            negateCycle <= bus.endStrobe;
        end
    end

    // Own the bus during termination and the negate clock
    assign busOe = bus.endStrobe || negateCycle;

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Ack and error are exclusive
    ackXorError: assert property (@(posedge CLK40) disable iff (TS_RESET)
        !(!nTA && !nTEA))
    else $error("ackDriver: nTA and nTEA low together");

    // One high clock with the bus driven, then release unless a new cycle ends
    negateOnce: assert property (@(posedge CLK40) disable iff (TS_RESET)
        bus.endStrobe ##1 !bus.endStrobe |->
            (busOe && nTA && nTEA && nTCI && nTBI) ##1 (bus.endStrobe || !busOe))
    else $error("ackDriver: missing or extra negate cycle after termination");

endmodule

// File: busCycleTop.sv
// Bus-cycle controller top for an MC68040 board, plain pins toward the processor bus
`timescale 1ns/1ps

module busCycleTop (
    input  logic         CLK40,
    input  logic         TS_RESET,
    input  logic         nTS,
    input  logic         OVL,
    input  logic [31:20] addr,
    output logic         nTA,
    output logic         nTEA,
    output logic         nTCI,
    output logic         nTBI,
    output logic         busOe,
    output logic         nROMEN
);
    import addrMapPkg::*;

    // Decoder output, sampled by the sequencer with nTS
    memRegion_t  region;
    regionAttr_t attr;

    // One decoded cycle between sequencer and driver
    cycleIf cyc ();

    addrDecode uDecode (
        .addr   (addr),
        .OVL    (OVL),
        .region (region),
        .attr   (attr)
    );

    cycleSequencer uSequencer (
        .CLK40    (CLK40),
        .TS_RESET (TS_RESET),
        .nTS      (nTS),
        .region   (region),
        .attr     (attr),
        .bus      (cyc),
        .nROMEN   (nROMEN)
    );

    ackDriver uAck (
        .CLK40    (CLK40),
        .TS_RESET (TS_RESET),
        .bus      (cyc),
        .nTA      (nTA),
        .nTEA     (nTEA),
        .nTCI     (nTCI),
        .nTBI     (nTBI),
        .busOe    (busOe)
    );

endmodule

// File: tbBusCycle.sv
// Testbench for busCycleTop that runs a region table and random addresses under run.sh
`timescale 1ns/1ps
`include "busCycle_macros.svh"

module tbBusCycle;
    import addrMapPkg::*;

    ////////////////////////////////////////
    // Run constants
    ////////////////////////////////////////

    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_COUNT = 40;
    localparam int TABLE_LEN = 16;
    localparam logic [31:0] RANDOM_SEED = 32'h3d9f8282;
    // Worst cycle is chip RAM with 6 clocks to termination plus negate and release
    localparam int WATCHDOG_CYCLES = (TABLE_LEN + RANDOM_COUNT) * 12 + RESET_CYCLES;

    // One table row of address code, overlay, expected region and chain flag
    typedef struct packed {
        logic [11:0] addrHi;
        logic        ovl;
        memRegion_t  region;
        logic        chainNext;
    } stimEntry_t;

    localparam stimEntry_t STIM [TABLE_LEN] = '{
        '{12'h00F, 1'b0, REGION_ROM,  1'b0},
        '{12'h000, 1'b0, REGION_CHIP, 1'b0},
        '{12'h001, 1'b0, REGION_CHIP, 1'b0},
        '{12'h00D, 1'b0, REGION_REG,  1'b0},
        '{12'h080, 1'b0, REGION_FAST, 1'b0},
        '{12'h0FF, 1'b0, REGION_FAST, 1'b0},
        '{12'h123, 1'b0, REGION_NONE, 1'b0},
        '{12'h00E, 1'b0, REGION_NONE, 1'b0},
        // Overlay maps chip space to ROM
        '{12'h000, 1'b1, REGION_ROM,  1'b0},
        '{12'h001, 1'b1, REGION_ROM,  1'b0},
        '{12'h00D, 1'b1, REGION_REG,  1'b0},
        // Back-to-back run at the earliest start
        '{12'h080, 1'b0, REGION_FAST, 1'b1},
        '{12'h7FF, 1'b0, REGION_NONE, 1'b1},
        '{12'h00F, 1'b1, REGION_ROM,  1'b1},
        '{12'h000, 1'b0, REGION_CHIP, 1'b0},
        '{12'hFFF, 1'b0, REGION_NONE, 1'b0}
    };

    ////////////////////////////////////////
    // DUT and clock
    ////////////////////////////////////////

    logic         CLK40;
    logic         TS_RESET;
    logic         nTS;
    logic         OVL;
    logic [31:20] addr;
    logic         nTA;
    logic         nTEA;
    logic         nTCI;
    logic         nTBI;
    logic         busOe;
    logic         nROMEN;

    busCycleTop DUT (
        .CLK40    (CLK40),
        .TS_RESET (TS_RESET),
        .nTS      (nTS),
        .OVL      (OVL),
        .addr     (addr),
        .nTA      (nTA),
        .nTEA     (nTEA),
        .nTCI     (nTCI),
        .nTBI     (nTBI),
        .busOe    (busOe),
        .nROMEN   (nROMEN)
    );

    // 40 ns period
    initial CLK40 = 1'b0;
    always #20 CLK40 = ~CLK40;

    ////////////////////////////////////////
    // Address-map model
    ////////////////////////////////////////

    // Region of an address code as the board map defines it
    function automatic memRegion_t modelRegion(input logic [31:20] a, input logic o);
        if (a[31:27] == `FAST_TOP_BITS) begin
            modelRegion = REGION_FAST;
        end else if (a == `ROM_BASE) begin
            modelRegion = REGION_ROM;
        end else if (a == `REG_BASE) begin
            modelRegion = REGION_REG;
        end else if ({a[31:21], 1'b0} == `CHIP_BASE) begin
            modelRegion = o ? REGION_ROM : REGION_CHIP;
        end else begin
            modelRegion = REGION_NONE;
        end
    endfunction

    // Wait states per region
    function automatic int modelWait(input memRegion_t r);
        case (r)
            REGION_ROM:  modelWait = `ROM_WAIT;
            REGION_CHIP: modelWait = `CHIP_WAIT;
            REGION_REG:  modelWait = `REG_WAIT;
            REGION_FAST: modelWait = `FAST_WAIT;
            default:     modelWait = `NONE_WAIT;
        endcase
    endfunction

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("FAIL %0t ns: %s, expected %0h, got %0h", $time, what, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Idle bus with busOe low and every active-low line high
    task automatic checkIdle(input string what);
        checkEqual(busOe, 1'b0, {what, ": busOe"});
        checkEqual(nTA, 1'b1, {what, ": nTA"});
        checkEqual(nTEA, 1'b1, {what, ": nTEA"});
        checkEqual(nTCI, 1'b1, {what, ": nTCI"});
        checkEqual(nTBI, 1'b1, {what, ": nTBI"});
        checkEqual(nROMEN, 1'b1, {what, ": nROMEN"});
    endtask

    // Mostly mapped codes with some fully random ones
    task automatic randomAddr(output logic [31:20] a, output logic o);
        logic [31:0] r;
        r = $urandom;
        case (r[15:13])
            3'd0: a = `ROM_BASE;
            3'd1: a = `CHIP_BASE | {11'd0, r[0]};
            3'd2: a = `REG_BASE;
            3'd3: a = {`FAST_TOP_BITS, r[6:0]};
            default: a = r[11:0];
        endcase
        o = r[16];
    endtask

    // One processor cycle that starts and returns on a falling edge
    // With chained set the previous cycle ended on this edge and its negate clock is still due
    // With holdNext set the task returns at termination so the next start lands on the earliest edge
    task automatic runCycle(input logic [31:20] a, input logic o, input memRegion_t expRegion,
                            input logic chained, input logic holdNext);
        int    waitCycles;
        int    cnt;
        logic  isError;
        logic  expCi;
        logic  expBi;
        string tag;
        waitCycles = modelWait(expRegion);
        isError = (expRegion == REGION_NONE);
        expCi = (expRegion == REGION_CHIP) || (expRegion == REGION_REG);
        expBi = (expRegion != REGION_FAST);
        tag = $sformatf("addr %h OVL %0b %s", a, o, expRegion.name());

        // nTS low for exactly one clock
        addr = a;
        OVL = o;
        nTS = 1'b0;
        @(posedge CLK40);
        @(negedge CLK40);
        nTS = 1'b1;
        cnt = 0;

        // No termination during the wait states
        while (nTA && nTEA) begin
            checkEqual(nTCI, 1'b1, {tag, ": nTCI before termination"});
            checkEqual(nTBI, 1'b1, {tag, ": nTBI before termination"});
            checkEqual(nROMEN, expRegion != REGION_ROM, {tag, ": nROMEN during cycle"});
            // Only the negate clock of a chained cycle may still drive the bus
            checkEqual(busOe, (cnt == 0) ? chained : 1'b0, {tag, ": busOe during cycle"});
            @(posedge CLK40);
            cnt++;
            @(negedge CLK40);
        end

        // Termination clock
        checkEqual(cnt, waitCycles + 1, {tag, ": clocks from nTS to termination"});
        checkEqual(nTA, isError, {tag, ": nTA at termination"});
        checkEqual(nTEA, !isError, {tag, ": nTEA at termination"});
        checkEqual(nTCI, !expCi, {tag, ": nTCI at termination"});
        checkEqual(nTBI, !expBi, {tag, ": nTBI at termination"});
        checkEqual(busOe, 1'b1, {tag, ": busOe at termination"});
        checkEqual(nROMEN, 1'b1, {tag, ": nROMEN at termination"});

        if (!holdNext) begin
            // Negate clock with every line driven high
            @(negedge CLK40);
            checkEqual(busOe, 1'b1, {tag, ": busOe in negate clock"});
            checkEqual(nTA, 1'b1, {tag, ": nTA in negate clock"});
            checkEqual(nTEA, 1'b1, {tag, ": nTEA in negate clock"});
            checkEqual(nTCI, 1'b1, {tag, ": nTCI in negate clock"});
            checkEqual(nTBI, 1'b1, {tag, ": nTBI in negate clock"});
            // Then release
            @(negedge CLK40);
            checkIdle({tag, " after release"});
        end
    endtask

    ////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK40);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $fatal(1, "Watchdog expired");
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        logic [31:20] a;
        logic         o;
        logic         chained;
        logic         chainNext;
        TS_RESET = 1'b1;
        nTS = 1'b1;
        OVL = 1'b0;
        addr = '0;
        void'($urandom(RANDOM_SEED));

        repeat (RESET_CYCLES) @(posedge CLK40);
        @(negedge CLK40);
        TS_RESET = 1'b0;
        @(negedge CLK40);
        checkIdle("after reset");

        // Table of regions, overlay and back-to-back runs
        chained = 1'b0;
        for (int i = 0; i < TABLE_LEN; i++) begin
            runCycle(STIM[i].addrHi, STIM[i].ovl, STIM[i].region, chained, STIM[i].chainNext);
            chained = STIM[i].chainNext;
        end

        // Random addresses checked against the model region
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            randomAddr(a, o);
            chainNext = (($urandom % 4) == 0) && (i != RANDOM_COUNT - 1);
            runCycle(a, o, modelRegion(a, o), chained, chainNext);
            chained = chainNext;
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+.
addrMapPkg.sv
busCyclePkg.sv
cycleIf.sv
addrDecode.sv
cycleSequencer.sv
ackDriver.sv
busCycleTop.sv
tbBusCycle.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the fail message

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -sv -Wno-fatal --top-module tbBusCycle \
    -f vlog.f -Mdir obj_dir -o tbBusCycle > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/tbBusCycle > sim.log 2>&1
cat sim.log

grep -q "=== FAIL ===" sim.log && { echo "Simulation failed"; exit 1; } \
    || { grep -q "=== PASS ===" sim.log && echo "Simulation passed" && exit 0; }
echo "Simulation ended without a result"
exit 1
